// File: fetch_pkg.sv
package fetch_pkg;

    // byte address width
    localparam int addr_width = 32;

    // one instruction word
    localparam int inst_width = 32;

    // bytes per memory block, also the cache line size
    localparam int block_bytes = 8;

    // most instructions handed to the buffer per cycle
    localparam int max_fetch = 4;

    // derived block geometry
    localparam int block_width = block_bytes * 8;
    localparam int offset_bits = $clog2(block_bytes);
    localparam int block_addr_width = addr_width - offset_bits;
    localparam int words_per_block = block_width / inst_width;

    // low pc bits inside one instruction word
    localparam int word_offset_bits = $clog2(inst_width / 8);

    // 0 to max_fetch instructions
    localparam int count_width = $clog2(max_fetch + 1);

    // one memory block
    // memory and cache move it as a double word,
    // the aligner picks instruction words out of it
    // word 0 sits at the lower address
    typedef union packed {
        logic [block_width-1:0] double_word;
        logic [words_per_block-1:0][inst_width-1:0] word;
    } mem_block;

endpackage

// File: fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl
    import fetch_pkg::*;
#(
    parameter int num_mem_tags = 15,
    parameter int prefetch_distance = 3
) (
    input  logic                         clock,
    input  logic                         reset,

    // redirect from the back end
    input  logic [addr_width-1:0]        target,
    input  logic                         squash,

    // memory may be used this cycle
    input  logic                         arbiter_grant,

    // state of the candidate blocks, block 0 holds npc
    input  logic [prefetch_distance-1:0] line_valid,
    input  logic [prefetch_distance-1:0] block_pending,
    input  logic                         table_full,

    // instructions the aligner hands over this cycle
    input  logic [count_width-1:0]       advance_count,

    output logic [addr_width-1:0]        npc,
    output logic                         mem_en,
    output logic [addr_width-1:0]        mem_addr
);

    // no use looking further ahead than the miss table can track
    localparam int walk_depth =
        (prefetch_distance < num_mem_tags) ? prefetch_distance : num_mem_tags;

    // registered fetch pc
    logic [addr_width-1:0] fetch_pc;

    // block number of npc
    logic [block_addr_width-1:0] npc_block;

    // chosen miss block and whether there is one
    logic [block_addr_width-1:0] pick_block;
    logic                        pick_found;

    // squash redirects in the same cycle
    assign npc = squash ? target : fetch_pc;

    assign npc_block = npc[addr_width-1:offset_bits];

    // walk from the far end down so the lowest miss wins
    // a block counts as a miss when neither cached nor already in flight
    always_comb begin
        pick_found = 1'b0;
        pick_block = npc_block;
        for (int i = walk_depth - 1; i >= 0; i--) begin
            if (!line_valid[i] && !block_pending[i]) begin
                pick_found = 1'b1;
                pick_block = npc_block + block_addr_width'(i);
            end
        end
    end

    // request only out of reset, with the bus granted and a free tag slot
    assign mem_en = !reset && arbiter_grant && !table_full && pick_found;

    // block aligned request address
    assign mem_addr = {pick_block, {offset_bits{1'b0}}};

    // step past whatever was delivered
    // aligner reports zero on a squash, so this lands on target
    always_ff @(posedge clock) begin
        if (reset) begin
            fetch_pc <= '0;
        end else begin
            fetch_pc <= npc + (addr_width'(advance_count) << word_offset_bits);
        end
    end

endmodule

// File: icache.sv
`timescale 1ns/1ps

module icache
    import fetch_pkg::*;
#(
    parameter int cache_lines = 32,
    parameter int prefetch_distance = 3
) (
    input  logic                         clock,
    input  logic                         reset,

    // lookup base
    input  logic [addr_width-1:0]        npc,

    // fill from the miss table on data return
    input  logic                         fill_en,
    input  logic [addr_width-1:0]        fill_addr,
    input  mem_block                     mem_data,

    // one read port per consecutive block
    output mem_block [prefetch_distance-1:0] line_data,
    output logic [prefetch_distance-1:0] line_valid
);

    localparam int index_bits = $clog2(cache_lines);
    localparam int tag_bits = block_addr_width - index_bits;

    // line storage
    mem_block            line_mem [cache_lines];
    logic [tag_bits-1:0] line_tag [cache_lines];

    // per line valid
    logic [cache_lines-1:0] line_ok;

    logic [block_addr_width-1:0] npc_block;
    logic [block_addr_width-1:0] fill_block;
    logic [index_bits-1:0]       fill_index;

    assign npc_block  = npc[addr_width-1:offset_bits];
    assign fill_block = fill_addr[addr_width-1:offset_bits];
    assign fill_index = fill_block[index_bits-1:0];

    // read port i looks at block npc + 8*i
    for (genvar i = 0; i < prefetch_distance; i++) begin : g_port
        logic [block_addr_width-1:0] rd_block;
        logic [index_bits-1:0]       rd_index;

        assign rd_block = npc_block + block_addr_width'(i);
        assign rd_index = rd_block[index_bits-1:0];

        assign line_data[i] = line_mem[rd_index];

        // hit needs a live line with matching upper bits
        assign line_valid[i] = line_ok[rd_index] &&
            (line_tag[rd_index] == rd_block[block_addr_width-1:index_bits]);
    end

    // valid bits, cleared only by reset
    always_ff @(posedge clock) begin
        if (reset) begin
            line_ok <= '0;
        end else if (fill_en) begin
            line_ok[fill_index] <= 1'b1;
        end
    end

    // data and tag, overwrite whatever lived at this index
    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_mem[fill_index] <= mem_data;
            line_tag[fill_index] <= fill_block[block_addr_width-1:index_bits];
        end
    end

endmodule

// File: mshr_table.sv
`timescale 1ns/1ps

module mshr_table
    import fetch_pkg::*;
#(
    parameter int num_mem_tags = 15,
    parameter int prefetch_distance = 3
) (
    input  logic                         clock,
    input  logic                         reset,

    // candidate base
    input  logic [addr_width-1:0]        npc,

    // request side, accepted when the tag is nonzero
    input  logic                         mem_en,
    input  logic [addr_width-1:0]        mem_addr,
    input  logic [$clog2(num_mem_tags+1)-1:0] mem_transaction_tag,

    // return side, 0 means nothing arrives
    input  logic [$clog2(num_mem_tags+1)-1:0] mem_data_tag,

    output logic [prefetch_distance-1:0] block_pending,
    output logic                         table_full,
    output logic                         fill_en,
    output logic [addr_width-1:0]        fill_addr
);

    // one entry per memory tag, tag 0 has none
    logic [block_addr_width-1:0] entry_block [num_mem_tags:1];
    logic [num_mem_tags:1]       entry_valid;

    logic                        accept;
    logic [block_addr_width-1:0] npc_block;

    assign npc_block = npc[addr_width-1:offset_bits];
    assign accept = mem_en && (mem_transaction_tag != '0);
    assign table_full = &entry_valid;

    // returning tag retires its entry and names the line to fill
    always_comb begin
        fill_en = 1'b0;
        fill_addr = '0;
        if (mem_data_tag != '0) begin
            fill_en = entry_valid[mem_data_tag];
            fill_addr = {entry_block[mem_data_tag], {offset_bits{1'b0}}};
        end
    end

    // each candidate against every live entry
    for (genvar i = 0; i < prefetch_distance; i++) begin : g_cand
        logic [block_addr_width-1:0] cand;
        logic                        hit;

        assign cand = npc_block + block_addr_width'(i);

        always_comb begin
            hit = 1'b0;
            for (int t = 1; t <= num_mem_tags; t++) begin
                if (entry_valid[t] && (entry_block[t] == cand)) begin
                    hit = 1'b1;
                end
            end
        end

        assign block_pending[i] = hit;
    end

    // retire first, a new grant of the same tag wins
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            if (fill_en) begin
                entry_valid[mem_data_tag] <= 1'b0;
            end
            if (accept) begin
                entry_valid[mem_transaction_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            entry_block[mem_transaction_tag] <= mem_addr[addr_width-1:offset_bits];
        end
    end

endmodule

// File: inst_aligner.sv
`timescale 1ns/1ps

module inst_aligner
    import fetch_pkg::*;
#(
    parameter int prefetch_distance = 3,
    parameter int ibuff_depth = 16
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         squash,
    input  logic [addr_width-1:0]        npc,

    // cache read ports, block 0 holds npc
    input  mem_block [prefetch_distance-1:0] line_data,
    input  logic [prefetch_distance-1:0] line_valid,

    // free buffer entries this cycle
    input  logic [$clog2(ibuff_depth+1)-1:0] ibuff_open,

    // same cycle count back to the pc
    output logic [count_width-1:0]       advance_count,

    output logic [max_fetch-1:0][inst_width-1:0] out_insts,
    output logic [addr_width-1:0]        out_pc,
    output logic [count_width-1:0]       out_num_insts
);

    // word of npc inside its block
    logic [offset_bits-word_offset_bits-1:0] first_word;

    logic [count_width-1:0]                  take_count;
    logic [max_fetch-1:0][inst_width-1:0]    next_insts;

    assign first_word = npc[offset_bits-1:word_offset_bits];

    // count words across the leading run of valid blocks
    // first block loses the words below npc
    always_comb begin
        int unsigned avail;
        int unsigned take;
        logic        run;

        avail = 0;
        run = 1'b1;
        for (int i = 0; i < prefetch_distance; i++) begin
            if (run && line_valid[i]) begin
                if (i == 0) begin
                    avail = words_per_block - int'(first_word);
                end else begin
                    avail = avail + words_per_block;
                end
            end else begin
                run = 1'b0;
            end
        end

        // clip to fetch width, then to buffer room
        take = avail;
        if (take > max_fetch) begin
            take = max_fetch;
        end
        if (take > ibuff_open) begin
            take = ibuff_open;
        end
        take_count = count_width'(take);
    end

    // output slot i takes word first_word + i of the run
    always_comb begin
        int slot;

        for (int i = 0; i < max_fetch; i++) begin
            slot = i + int'(first_word);
            next_insts[i] = '0;
            if (slot / words_per_block < prefetch_distance) begin
                next_insts[i] =
                    line_data[slot / words_per_block].word[slot % words_per_block];
            end
        end
    end

    // nothing delivered out of a squash cycle
    assign advance_count = squash ? '0 : take_count;

    always_ff @(posedge clock) begin
        if (reset || squash) begin
            out_num_insts <= '0;
        end else begin
            out_num_insts <= take_count;
        end
    end

    // words and pc only mean something with a nonzero count
    always_ff @(posedge clock) begin
        out_insts <= next_insts;
        out_pc <= npc;
    end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import fetch_pkg::*;
#(
    parameter int num_mem_tags = 15,
    parameter int cache_lines = 32,
    parameter int prefetch_distance = 3,
    parameter int ibuff_depth = 16
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [addr_width-1:0]                target,
    input  logic                                 squash,
    input  logic [$clog2(ibuff_depth+1)-1:0]     ibuff_open,
    input  logic                                 arbiter_grant,
    input  logic [$clog2(num_mem_tags+1)-1:0]    mem_transaction_tag,
    input  logic [$clog2(num_mem_tags+1)-1:0]    mem_data_tag,
    input  mem_block                             mem_data,
    output logic                                 mem_en,
    output logic [addr_width-1:0]                mem_addr,
    output logic [max_fetch-1:0][inst_width-1:0] out_insts,
    output logic [addr_width-1:0]                out_pc,
    output logic [count_width-1:0]               out_num_insts,
    output logic [addr_width-1:0]                npc
);

    // cache read ports
    mem_block [prefetch_distance-1:0] line_data;
    logic [prefetch_distance-1:0]     line_valid;

    // miss table state
    logic [prefetch_distance-1:0]     block_pending;
    logic                             table_full;
    logic                             fill_en;
    logic [addr_width-1:0]            fill_addr;

    // aligner to pc
    logic [count_width-1:0]           advance_count;

    fetch_ctrl #(
        .num_mem_tags      (num_mem_tags),
        .prefetch_distance (prefetch_distance)
    ) i_fetch_ctrl (
        .clock         (clock),
        .reset         (reset),
        .target        (target),
        .squash        (squash),
        .arbiter_grant (arbiter_grant),
        .line_valid    (line_valid),
        .block_pending (block_pending),
        .table_full    (table_full),
        .advance_count (advance_count),
        .npc           (npc),
        .mem_en        (mem_en),
        .mem_addr      (mem_addr)
    );

    icache #(
        .cache_lines       (cache_lines),
        .prefetch_distance (prefetch_distance)
    ) i_icache (
        .clock      (clock),
        .reset      (reset),
        .npc        (npc),
        .fill_en    (fill_en),
        .fill_addr  (fill_addr),
        .mem_data   (mem_data),
        .line_data  (line_data),
        .line_valid (line_valid)
    );

    mshr_table #(
        .num_mem_tags      (num_mem_tags),
        .prefetch_distance (prefetch_distance)
    ) i_mshr_table (
        .clock               (clock),
        .reset               (reset),
        .npc                 (npc),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .block_pending       (block_pending),
        .table_full          (table_full),
        .fill_en             (fill_en),
        .fill_addr           (fill_addr)
    );

    inst_aligner #(
        .prefetch_distance (prefetch_distance),
        .ibuff_depth       (ibuff_depth)
    ) i_inst_aligner (
        .clock         (clock),
        .reset         (reset),
        .squash        (squash),
        .npc           (npc),
        .line_data     (line_data),
        .line_valid    (line_valid),
        .ibuff_open    (ibuff_open),
        .advance_count (advance_count),
        .out_insts     (out_insts),
        .out_pc        (out_pc),
        .out_num_insts (out_num_insts)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // held over the first 5 rising edges
    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

// File: fetch_stage_tb.sv
`timescale 1ns/1ps

module fetch_stage_tb
    import fetch_pkg::*;
();

    localparam int num_mem_tags = 15;
    localparam int cache_lines = 32;
    localparam int prefetch_distance = 3;
    localparam int ibuff_depth = 16;
    localparam int tag_width = $clog2(num_mem_tags + 1);
    localparam int open_width = $clog2(ibuff_depth + 1);
    localparam int num_rows = 8;

    // memory word at byte address a holds a ^ inst_key
    localparam logic [inst_width-1:0] inst_key = 32'h5a3c_0f96;

    // run length, ibuff_open, grant %, refuse %, squash, target, no memory traffic
    int rows [num_rows][7] = '{
        '{45, 4, 100,  0, 0, 'h00, 0},
        '{20, 4, 100,  0, 1, 'h6c, 0},
        '{ 8, 1, 100,  0, 1, 'h00, 1},
        '{15, 0, 100,  0, 0, 'h00, 0},
        '{25, 3, 100, 80, 0, 'h00, 0},
        '{20, 4,   0,  0, 0, 'h00, 0},
        '{30, 1,  60, 30, 1, 'hc4, 0},
        '{40, 4,  70, 20, 1, 'h1c, 0}
    };

    logic                                 clock;
    logic                                 reset;
    logic [addr_width-1:0]                target = '0;
    logic                                 squash = 1'b0;
    logic [open_width-1:0]                ibuff_open = '0;
    logic                                 arbiter_grant = 1'b0;
    logic [tag_width-1:0]                 mem_transaction_tag = '0;
    logic [tag_width-1:0]                 mem_data_tag = '0;
    mem_block                             mem_data = '0;
    logic                                 mem_en;
    logic [addr_width-1:0]                mem_addr;
    logic [max_fetch-1:0][inst_width-1:0] out_insts;
    logic [addr_width-1:0]                out_pc;
    logic [count_width-1:0]               out_num_insts;
    logic [addr_width-1:0]                npc;

    // memory model, one slot per tag
    logic                  inflight_valid [1:num_mem_tags] = '{default: 1'b0};
    logic [addr_width-1:0] inflight_addr [1:num_mem_tags];
    int                    inflight_due [1:num_mem_tags];
    int                    rot_tag = 1;

    // row settings seen by the model
    int grant_pct = 0;
    int refuse_pct = 0;
    int row_idx = 0;
    int row_deliv [num_rows] = '{default: 0};
    int row_reqs [num_rows] = '{default: 0};

    int                    cycle_count = 0;
    int                    cycle_limit = 0;
    logic [addr_width-1:0] exp_pc = '0;
    logic                  prev_reset = 1'b1;
    logic                  prev_squash = 1'b0;
    int                    prev_open = 0;

    tb_clock_gen i_tb_clock_gen (
        .clock (clock),
        .reset (reset)
    );

    fetch_stage #(
        .num_mem_tags      (num_mem_tags),
        .cache_lines       (cache_lines),
        .prefetch_distance (prefetch_distance),
        .ibuff_depth       (ibuff_depth)
    ) i_fetch_stage (
        .clock               (clock),
        .reset               (reset),
        .target              (target),
        .squash              (squash),
        .ibuff_open          (ibuff_open),
        .arbiter_grant       (arbiter_grant),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data_tag        (mem_data_tag),
        .mem_data            (mem_data),
        .mem_en              (mem_en),
        .mem_addr            (mem_addr),
        .out_insts           (out_insts),
        .out_pc              (out_pc),
        .out_num_insts       (out_num_insts),
        .npc                 (npc)
    );

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input logic [addr_width-1:0] got,
                              input logic [addr_width-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_inst(input string name, input logic [inst_width-1:0] got,
                              input logic [inst_width-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input logic [count_width-1:0] got,
                               input logic [count_width-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    // two words, lower address first
    function automatic mem_block block_data(input logic [addr_width-1:0] addr);
        mem_block blk;
        blk.word[0] = addr ^ inst_key;
        blk.word[1] = (addr + 32'd4) ^ inst_key;
        return blk;
    endfunction

    // every edge looks back at the cycle that just ended, then drives the next one
    always @(posedge clock) begin : model
        int t;
        int n;
        int pick;

        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            stop_run($sformatf("timeout: stimulus not finished after %0d cycles", cycle_count));
        end
        if (reset) begin
            if (mem_en !== 1'b0) begin
                stop_run("mem_en was high during reset");
            end
            // grant held high so only reset keeps mem_en low
            arbiter_grant <= 1'b1;
            mem_transaction_tag <= '0;
            mem_data_tag <= '0;
        end else begin
            if (!arbiter_grant && mem_en !== 1'b0) begin
                stop_run("mem_en was high without arbiter grant");
            end
            if (mem_en === 1'b1) begin
                if (mem_addr[offset_bits-1:0] != '0) begin
                    stop_run($sformatf("mem_addr %h is not aligned to a block", mem_addr));
                end
                for (t = 1; t <= num_mem_tags; t++) begin
                    if (inflight_valid[t] && inflight_addr[t] == mem_addr) begin
                        stop_run($sformatf("block %h requested again while in flight", mem_addr));
                    end
                end
                // accepted request, return due 4 to 10 cycles later
                if (mem_transaction_tag != '0) begin
                    inflight_valid[mem_transaction_tag] = 1'b1;
                    inflight_addr[mem_transaction_tag] = mem_addr;
                    inflight_due[mem_transaction_tag] = cycle_count + 4 + int'($urandom % 7);
                    rot_tag = int'(mem_transaction_tag) % num_mem_tags + 1;
                    row_reqs[row_idx] = row_reqs[row_idx] + 1;
                end
            end
            if (mem_data_tag != '0) begin
                inflight_valid[mem_data_tag] = 1'b0;
            end

            // delivered words against the tracked pc
            if (!prev_reset) begin
                n = int'(out_num_insts);
                if (prev_squash) begin
                    check_count("out_num_insts", out_num_insts, '0);
                end
                if (n > max_fetch || n > prev_open) begin
                    stop_run($sformatf("Error at %0t: out_num_insts is %0d, open entries were %0d",
                                       $time, n, prev_open));
                end
                if (n > 0) begin
                    check_addr("out_pc", out_pc, exp_pc);
                    for (int i = 0; i < n; i++) begin
                        check_inst($sformatf("out_insts[%0d]", i), out_insts[i],
                                   (exp_pc + addr_width'(4 * i)) ^ inst_key);
                    end
                    exp_pc = exp_pc + addr_width'(4 * n);
                    row_deliv[row_idx] = row_deliv[row_idx] + n;
                end
                if (squash) begin
                    exp_pc = target;
                end
                // npc sits where the next delivery starts, so no room means no movement
                check_addr("npc", npc, exp_pc);
            end

            arbiter_grant <= (int'($urandom % 100) < grant_pct);
            // rotating tag, skipping any still in flight
            pick = 0;
            for (int k = 0; k < num_mem_tags; k++) begin
                t = (rot_tag - 1 + k) % num_mem_tags + 1;
                if (pick == 0 && !inflight_valid[t]) begin
                    pick = t;
                end
            end
            if (int'($urandom % 100) < refuse_pct) begin
                pick = 0;
            end
            mem_transaction_tag <= tag_width'(pick);
            // first due entry returns its block
            pick = 0;
            for (t = 1; t <= num_mem_tags; t++) begin
                if (pick == 0 && inflight_valid[t] && inflight_due[t] <= cycle_count) begin
                    pick = t;
                end
            end
            mem_data_tag <= tag_width'(pick);
            if (pick != 0) begin
                mem_data <= block_data(inflight_addr[pick]);
            end else begin
                mem_data <= '0;
            end
        end
        prev_reset = reset;
        prev_squash = squash;
        prev_open = int'(ibuff_open);
    end

    initial begin : stimulus
        string why;

        void'($urandom(7));
        cycle_limit = 200;
        for (int r = 0; r < num_rows; r++) begin
            cycle_limit = cycle_limit + rows[r][0];
        end
        @(posedge clock);
        while (reset) begin
            @(posedge clock);
        end

        // one row per pass, squash only in the first cycle
        for (int r = 0; r < num_rows; r++) begin
            @(posedge clock);
            row_idx <= r;
            ibuff_open <= open_width'(rows[r][1]);
            grant_pct <= rows[r][2];
            refuse_pct <= rows[r][3];
            squash <= (rows[r][4] != 0);
            target <= addr_width'(rows[r][5]);
            @(posedge clock);
            squash <= 1'b0;
            repeat (rows[r][0] - 2) @(posedge clock);
        end
        @(negedge clock);

        why = "";
        for (int r = 0; r < num_rows; r++) begin
            if (why == "" && rows[r][1] > 0 && rows[r][2] > 0 && row_deliv[r] == 0) begin
                why = $sformatf("row %0d delivered no instructions", r);
            end
            if (why == "" && rows[r][6] != 0 && row_reqs[r] != 0) begin
                why = $sformatf("row %0d went to memory for cached code", r);
            end
        end
        if (why == "") begin
            $display("Test passed");
            $finish;
        end else begin
            stop_run(why);
        end
    end

endmodule

// File: fetch_stage.f
fetch_pkg.sv
fetch_ctrl.sv
icache.sv
mshr_table.sv
inst_aligner.sv
fetch_stage.sv
tb_clock_gen.sv
fetch_stage_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing
TOP       := fetch_stage_tb
RTL_TOP   := fetch_stage
FILELIST  := fetch_stage.f
PASS_MSG  := Test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
